// File: dv/uartApbTb.sv
`timescale 1ns/1ps

module uartApbTb;
    import uartPkg::*;

    localparam int baudVal    = 3;                          // tick every 4 clocks
    localparam int bitClocks  = overSample * (baudVal + 1); // clocks per serial bit
    localparam int frameCount = 10;                         // frames over all tests
    localparam int frameBits  = 13;                         // 11 bits worst case plus gaps
    localparam int busCycles  = 400;                        // register traffic allowance
    localparam int timeoutCycles = 2 * (frameCount * frameBits * bitClocks + busCycles);

    logic                 PCLK;
    logic                 PRESETN;
    logic [addrWidth-1:0] PADDR;
    logic                 PSEL;
    logic                 PENABLE;
    logic                 PWRITE;
    logic [dataWidth-1:0] PWDATA;
    logic [dataWidth-1:0] PRDATA;
    logic                 TXRDY;
    logic                 RXRDY;
    logic                 RX;
    logic                 TX;
    logic                 PARITY_ERR;
    logic                 OVERFLOW;
    int                   cycleCount = 0;
    int                   seed = 97;

    uartApb #(
        .fixedMode (1'b0)      // registers drive the frame format
    ) i_uartApb (
        .PCLK       (PCLK),
        .PRESETN    (PRESETN),
        .PADDR      (PADDR),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PWRITE     (PWRITE),
        .PWDATA     (PWDATA),
        .PRDATA     (PRDATA),
        .TXRDY      (TXRDY),
        .RXRDY      (RXRDY),
        .RX         (RX),
        .TX         (TX),
        .PARITY_ERR (PARITY_ERR),
        .OVERFLOW   (OVERFLOW)
    );

    always #20 PCLK = ~PCLK;   // 40 ns period

    // run limit scaled from frame count and bit length
    always @(posedge PCLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("simulation ran past %0d cycles without finishing", timeoutCycles);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic checkByte(input string testName, input logic [dataWidth-1:0] expected,
                             input logic [dataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%h, actual 0x%h", testName, expected, actual);
            $display("Testbench failed");
            $fatal(1, "wrong byte value");
        end
    endtask

    task automatic checkFlag(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %b, actual %b", testName, expected, actual);
            $display("Testbench failed");
            $fatal(1, "wrong flag value");
        end
    endtask

    // parity bit that a correct frame carries
    function automatic logic parityOf(input logic [dataWidth-1:0] d, input bit bit8,
                                      input bit odd);
        logic p;
        p = bit8 ? ^d : ^d[6:0];   // even parity makes the total ones even
        return odd ? ~p : p;
    endfunction

    // ----------------------------------------
    // APB driver entered and left on a falling edge
    // ----------------------------------------
    task automatic apbWrite(input logic [2:0] offs, input logic [dataWidth-1:0] data);
        PADDR   = {offs, 2'b00};
        PWDATA  = data;
        PWRITE  = 1'b1;
        PSEL    = 1'b1;      // setup
        PENABLE = 1'b0;
        @(negedge PCLK);
        PENABLE = 1'b1;      // access
        @(negedge PCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic apbRead(input logic [2:0] offs, output logic [dataWidth-1:0] data);
        PADDR   = {offs, 2'b00};
        PWRITE  = 1'b0;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        @(negedge PCLK);
        PENABLE = 1'b1;      // PRDATA already registered
        @(negedge PCLK);
        data    = PRDATA;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic setFormat(input bit bit8, input bit parEn, input bit odd);
        apbWrite(ctrl1Offs, dataWidth'(baudVal));
        apbWrite(ctrl2Offs, {5'd0, odd, parEn, bit8});   // high baud bits stay 0
    endtask

    // ----------------------------------------
    // serial line driver and monitor
    // ----------------------------------------
    task automatic serialSend(input logic [dataWidth-1:0] data, input bit bit8,
                              input bit parEn, input bit odd, input bit badParity,
                              input bit lowStop);
        int i;
        RX = 1'b0;                               // start bit
        repeat (bitClocks) @(negedge PCLK);
        for (i = 0; i < (bit8 ? 8 : 7); i++) begin
            RX = data[i];                        // LSB first
            repeat (bitClocks) @(negedge PCLK);
        end
        if (parEn) begin
            RX = parityOf(data, bit8, odd) ^ badParity;
            repeat (bitClocks) @(negedge PCLK);
        end
        RX = !lowStop;
        // a low stop bit is cut short so its tail is not taken for a new start
        repeat (lowStop ? bitClocks * 5 / 8 : bitClocks) @(negedge PCLK);
        RX = 1'b1;
        repeat (bitClocks) @(negedge PCLK);      // idle gap
    endtask

    task automatic serialCapture(input bit bit8, input bit parEn,
                                 output logic [dataWidth-1:0] data, output logic startBit,
                                 output logic parBit, output logic stopBit);
        int i;
        data   = '0;
        parBit = 1'b0;
        while (TX === 1'b1)
            @(negedge PCLK);                     // wait for the start edge
        repeat (bitClocks / 2) @(negedge PCLK);  // to the bit centre
        startBit = TX;
        for (i = 0; i < (bit8 ? 8 : 7); i++) begin
            repeat (bitClocks) @(negedge PCLK);
            data[i] = TX;
        end
        if (parEn) begin
            repeat (bitClocks) @(negedge PCLK);
            parBit = TX;
        end
        repeat (bitClocks) @(negedge PCLK);
        stopBit = TX;
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic regAccess();
        logic [dataWidth-1:0] val;
        logic [dataWidth-1:0] rd;
        checkByte("regAccess PRDATA after reset", '0, PRDATA);
        apbRead(statusOffs, rd);
        checkByte("regAccess status after reset", 8'h01, rd);   // only TXRDY
        val = $urandom;
        apbWrite(ctrl1Offs, val);
        apbRead(ctrl1Offs, rd);
        checkByte("regAccess control 1", val, rd);
        val = $urandom;
        apbWrite(ctrl2Offs, val);
        apbRead(ctrl2Offs, rd);
        checkByte("regAccess control 2", val, rd);
        apbRead(txDataOffs, rd);
        checkByte("regAccess offset 0", '0, rd);
    endtask

    task automatic transmitFrame(input bit bit8, input bit parEn, input bit odd);
        logic [dataWidth-1:0] sent;
        logic [dataWidth-1:0] got;
        logic [dataWidth-1:0] stat;
        logic                 startBit;
        logic                 parBit;
        logic                 stopBit;
        setFormat(bit8, parEn, odd);
        sent = $urandom;
        apbWrite(txDataOffs, sent);
        checkFlag("transmitFrame TXRDY port after write", 1'b0, TXRDY);
        fork
            apbRead(statusOffs, stat);           // holding reg still full here
            serialCapture(bit8, parEn, got, startBit, parBit, stopBit);
        join
        checkFlag("transmitFrame TXRDY after write", 1'b0, stat[0]);
        checkFlag("transmitFrame start bit", 1'b0, startBit);
        checkByte("transmitFrame data", bit8 ? sent : (sent & 8'h7f), got);
        if (parEn)
            checkFlag("transmitFrame parity bit", parityOf(sent, bit8, odd), parBit);
        checkFlag("transmitFrame stop bit", 1'b1, stopBit);
        apbRead(statusOffs, stat);               // still inside the stop bit
        checkFlag("transmitFrame TXRDY before frame end", 1'b1, stat[0]);
        checkFlag("transmitFrame TXRDY port before frame end", 1'b1, TXRDY);
        repeat (bitClocks) @(negedge PCLK);
    endtask

    task automatic receiveFrame(input bit bit8, input bit parEn, input bit odd);
        logic [dataWidth-1:0] sent;
        logic [dataWidth-1:0] got;
        setFormat(bit8, parEn, odd);
        sent = $urandom;
        serialSend(sent, bit8, parEn, odd, 1'b0, 1'b0);
        checkFlag("receiveFrame RXRDY", 1'b1, RXRDY);
        apbRead(rxDataOffs, got);
        checkByte("receiveFrame data", bit8 ? sent : (sent & 8'h7f), got);
        checkFlag("receiveFrame RXRDY after read", 1'b0, RXRDY);
    endtask

    task automatic receiveErrors();
        logic [dataWidth-1:0] rd;
        setFormat(1'b1, 1'b1, 1'b0);             // 8 bits with even parity
        serialSend($urandom, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
        checkFlag("receiveErrors PARITY_ERR set", 1'b1, PARITY_ERR);
        apbRead(rxDataOffs, rd);
        checkFlag("receiveErrors PARITY_ERR cleared", 1'b0, PARITY_ERR);
        serialSend($urandom, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        apbRead(statusOffs, rd);
        checkFlag("receiveErrors framing set", 1'b1, rd[4]);
        apbRead(rxDataOffs, rd);
        apbRead(statusOffs, rd);
        checkFlag("receiveErrors framing cleared", 1'b0, rd[4]);
    endtask

    task automatic overflow();
        logic [dataWidth-1:0] first;
        logic [dataWidth-1:0] second;
        logic [dataWidth-1:0] got;
        setFormat(1'b1, 1'b0, 1'b0);
        first  = $urandom;
        second = $urandom;
        serialSend(first, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        serialSend(second, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);   // no read in between
        checkFlag("overflow OVERFLOW set", 1'b1, OVERFLOW);
        apbRead(rxDataOffs, got);
        checkByte("overflow data", second, got);
        checkFlag("overflow OVERFLOW cleared", 1'b0, OVERFLOW);
    endtask

    // ----------------------------------------
    // sequence
    // ----------------------------------------
    initial begin
        void'($urandom(seed));
        PCLK    = 1'b0;
        PRESETN = 1'b0;
        PADDR   = '0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PWDATA  = '0;
        RX      = 1'b1;                          // line idle
        repeat (10) @(negedge PCLK);
        PRESETN = 1'b1;
        @(negedge PCLK);
        regAccess();
        transmitFrame(1'b1, 1'b0, 1'b0);         // 8N1
        transmitFrame(1'b0, 1'b1, 1'b0);         // 7 bits even
        transmitFrame(1'b1, 1'b1, 1'b1);         // 8 bits odd
        receiveFrame(1'b1, 1'b0, 1'b0);
        receiveFrame(1'b0, 1'b1, 1'b0);
        receiveFrame(1'b1, 1'b1, 1'b1);
        receiveErrors();
        overflow();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: hdl/uartApb.sv
`timescale 1ns/1ps

module uartApb #(
    parameter bit                             fixedMode   = 1'b0,
    parameter logic [uartPkg::baudWidth-1:0]  fixedBaud   = '0,
    parameter bit                             fixedBit8   = 1'b0,
    parameter int                             fixedParity = 0
) (
    input  logic                          PCLK,
    input  logic                          PRESETN,
    input  logic [uartPkg::addrWidth-1:0] PADDR,
    input  logic                          PSEL,
    input  logic                          PENABLE,
    input  logic                          PWRITE,
    input  logic [uartPkg::dataWidth-1:0] PWDATA,
    output logic [uartPkg::dataWidth-1:0] PRDATA,
    output logic                          TXRDY,
    output logic                          RXRDY,
    input  logic                          RX,
    output logic                          TX,
    output logic                          PARITY_ERR,
    output logic                          OVERFLOW
);
    import uartPkg::*;

    logic                 txWrite;
    logic [dataWidth-1:0] txData;
    logic                 rxRead;
    logic [dataWidth-1:0] rxData;
    logic                 tick;
    logic                 framingErr;  // status bit 4 only

    uartCfgIf cfgIf ();

    uartApbRegs #(
        .fixedMode   (fixedMode),
        .fixedBaud   (fixedBaud),
        .fixedBit8   (fixedBit8),
        .fixedParity (fixedParity)
    ) i_uartApbRegs (
        .PCLK       (PCLK),
        .PRESETN    (PRESETN),
        .PADDR      (PADDR),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PWRITE     (PWRITE),
        .PWDATA     (PWDATA),
        .PRDATA     (PRDATA),
        .rxData     (rxData),
        .txRdy      (TXRDY),
        .rxRdy      (RXRDY),
        .parityErr  (PARITY_ERR),
        .overflow   (OVERFLOW),
        .framingErr (framingErr),
        .txWrite    (txWrite),
        .txData     (txData),
        .rxRead     (rxRead),
        .cfg        (cfgIf.cfgSrc)
    );

    uartBaudGen i_uartBaudGen (
        .PCLK    (PCLK),
        .PRESETN (PRESETN),
        .cfg     (cfgIf.cfgSink),
        .tick    (tick)
    );

    uartTx i_uartTx (
        .PCLK    (PCLK),
        .PRESETN (PRESETN),
        .tick    (tick),
        .txWrite (txWrite),
        .txData  (txData),
        .cfg     (cfgIf.cfgSink),
        .TX      (TX),
        .txRdy   (TXRDY)
    );

    uartRx i_uartRx (
        .PCLK       (PCLK),
        .PRESETN    (PRESETN),
        .tick       (tick),
        .RX         (RX),
        .rxRead     (rxRead),
        .cfg        (cfgIf.cfgSink),
        .rxData     (rxData),
        .rxRdy      (RXRDY),
        .parityErr  (PARITY_ERR),
        .overflow   (OVERFLOW),
        .framingErr (framingErr)
    );

endmodule

// File: hdl/uartApbRegs.sv
`timescale 1ns/1ps

module uartApbRegs #(
    parameter bit                             fixedMode   = 1'b0,  // 1 = config from parameters
    parameter logic [uartPkg::baudWidth-1:0]  fixedBaud   = '0,
    parameter bit                             fixedBit8   = 1'b0,
    parameter int                             fixedParity = 0      // 0 none, 1 odd, 2 even
) (
    input  logic                          PCLK,
    input  logic                          PRESETN,
    input  logic [uartPkg::addrWidth-1:0] PADDR,
    input  logic                          PSEL,
    input  logic                          PENABLE,
    input  logic                          PWRITE,
    input  logic [uartPkg::dataWidth-1:0] PWDATA,
    output logic [uartPkg::dataWidth-1:0] PRDATA,
    input  logic [uartPkg::dataWidth-1:0] rxData,
    input  logic                          txRdy,
    input  logic                          rxRdy,
    input  logic                          parityErr,
    input  logic                          overflow,
    input  logic                          framingErr,
    output logic                          txWrite,     // one-cycle write strobe
    output logic [uartPkg::dataWidth-1:0] txData,
    output logic                          rxRead,      // one-cycle read strobe
    uartCfgIf.cfgSrc                      cfg
);
    import uartPkg::*;

    logic [2:0]             regIdx;
    logic                   setupRead;
    logic                   accessWrite;
    logic                   accessRead;
    logic [dataWidth-1:0]   ctrl1;
    logic [dataWidth-1:0]   ctrl2;
    logic [dataWidth-1:0]   rdMux;
    logic [statusWidth-1:0] status;
    logic                   fixParEn;
    logic                   fixOdd;

    assign regIdx      = PADDR[4:2];                    // word index
    assign setupRead   = PSEL && !PENABLE && !PWRITE;   // read data is picked here
    assign accessWrite = PSEL && PENABLE && PWRITE;
    assign accessRead  = PSEL && PENABLE && !PWRITE;

    assign txWrite = accessWrite && (regIdx == txDataOffs);
    assign txData  = PWDATA;
    assign rxRead  = accessRead && (regIdx == rxDataOffs);    // pops the rx holding reg

    // ----------------------------------------
    // control registers
    // ----------------------------------------
    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            ctrl1 <= '0;
            ctrl2 <= '0;
        end else if (accessWrite) begin
            if (regIdx == ctrl1Offs)
                ctrl1 <= PWDATA;
            if (regIdx == ctrl2Offs)
                ctrl2 <= PWDATA;
        end
    end

    // fixed parity code 1 is odd, 2 is even
    assign fixParEn = (fixedParity == 1) || (fixedParity == 2);
    assign fixOdd   = (fixedParity == 1);

    assign cfg.baudVal   = fixedMode ? fixedBaud : {ctrl2[dataWidth-1:3], ctrl1};
    assign cfg.bit8      = fixedMode ? fixedBit8 : ctrl2[0];
    assign cfg.parityEn  = fixedMode ? fixParEn  : ctrl2[1];
    assign cfg.oddParity = fixedMode ? fixOdd    : ctrl2[2];

    // ----------------------------------------
    // read path
    // ----------------------------------------
    assign status = {framingErr, overflow, parityErr, rxRdy, txRdy};

    always_comb begin
        case (regIdx)
            rxDataOffs: rdMux = rxData;
            ctrl1Offs:  rdMux = ctrl1;
            ctrl2Offs:  rdMux = ctrl2;
            statusOffs: rdMux = {{(dataWidth - statusWidth){1'b0}}, status};
            default:    rdMux = '0;          // tx data and unmapped offsets
        endcase
    end

    // registered at the end of setup, held between reads
    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN)
            PRDATA <= '0;
        else if (setupRead)
            PRDATA <= rdMux;
    end

    // an access phase is only ever seen inside a selected transfer
    apbEnableNeedsSel: assert property (
        @(posedge PCLK) disable iff (!PRESETN) PENABLE |-> PSEL
    );

endmodule

// File: hdl/uartBaudGen.sv
`timescale 1ns/1ps

module uartBaudGen (
    input  logic       PCLK,
    input  logic       PRESETN,
    uartCfgIf.cfgSink  cfg,
    output logic       tick       // one pulse per baudVal+1 clocks
);
    import uartPkg::*;

    logic [baudWidth-1:0] cnt;        // down-counter
    logic [baudWidth-1:0] baudLast;   // value the counter was last loaded from

    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            cnt      <= '0;
            baudLast <= '0;
            tick     <= 1'b0;
        end else if (cfg.baudVal != baudLast) begin
            baudLast <= cfg.baudVal;  // new rate, start the period over
            cnt      <= cfg.baudVal;
            tick     <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= cfg.baudVal;      // reload and pulse
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    // back-to-back ticks only at the fastest setting
    tickSpacing: assert property (
        @(posedge PCLK) disable iff (!PRESETN) tick && (cfg.baudVal != '0) |=> !tick
    );

endmodule

// File: hdl/uartCfgIf.sv
`timescale 1ns/1ps

// frame configuration shared by the baud generator and both serial engines
interface uartCfgIf;
    import uartPkg::*;

    logic [baudWidth-1:0] baudVal;  // tick period is baudVal+1 clocks
    logic                 bit8;     // 1 = eight data bits, 0 = seven
    logic                 parityEn; // parity bit present in the frame
    logic                 oddParity; // 1 = odd, 0 = even

    modport cfgSrc (
        output baudVal,
        output bit8,
        output parityEn,
        output oddParity
    );

    modport cfgSink (
        input baudVal,
        input bit8,
        input parityEn,
        input oddParity
    );
endinterface

// File: hdl/uartPkg.sv
package uartPkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int dataWidth   = 8;     // data byte and APB data bus
    localparam int baudWidth   = 13;    // baud divider value
    localparam int addrWidth   = 5;     // PADDR width
    localparam int statusWidth = 5;     // used bits of the status register

    // ticks per serial bit, both directions
    localparam int overSample = 16;

    // ----------------------------------------
    // register indices (PADDR[4:2])
    // ----------------------------------------
    localparam logic [2:0] txDataOffs = 3'd0;   // write only
    localparam logic [2:0] rxDataOffs = 3'd1;   // read only
    localparam logic [2:0] ctrl1Offs  = 3'd2;   // low baud bits
    localparam logic [2:0] ctrl2Offs  = 3'd3;   // high baud bits and frame format
    localparam logic [2:0] statusOffs = 3'd4;   // read only

endpackage

// File: hdl/uartRx.sv
`timescale 1ns/1ps

module uartRx (
    input  logic                          PCLK,
    input  logic                          PRESETN,
    input  logic                          tick,
    input  logic                          RX,
    input  logic                          rxRead,
    uartCfgIf.cfgSink                     cfg,
    output logic [uartPkg::dataWidth-1:0] rxData,
    output logic                          rxRdy,
    output logic                          parityErr,
    output logic                          overflow,
    output logic                          framingErr
);
    import uartPkg::*;

    localparam logic [2:0] sIdle   = 3'd0;
    localparam logic [2:0] sStart  = 3'd1;
    localparam logic [2:0] sData   = 3'd2;
    localparam logic [2:0] sParity = 3'd3;
    localparam logic [2:0] sStop   = 3'd4;
    localparam int tickBits = $clog2(overSample);
    localparam int bitBits  = $clog2(dataWidth);

    logic                 rxMeta;
    logic                 rxSync;      // RX after two flops
    logic [2:0]           state;
    logic [tickBits-1:0]  tickCnt;
    logic [bitBits-1:0]   bitCnt;
    logic [dataWidth-1:0] dataReg;     // assembly register
    logic                 parAcc;
    logic                 parErrPend;  // parity result until the stop bit
    logic                 midStart;
    logic                 startOk;
    logic                 bitEnd;
    logic                 lastBit;
    logic                 sampleData;
    logic                 stopSample;

    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= RX;
            rxSync <= rxMeta;
        end
    end

    assign midStart   = tick && (tickCnt == tickBits'(overSample / 2 - 1));  // tick 8
    assign startOk    = (state == sStart) && midStart && !rxSync;
    assign bitEnd     = tick && (tickCnt == tickBits'(overSample - 1));    // bit centre
    assign lastBit    = (bitCnt == (cfg.bit8 ? bitBits'(7) : bitBits'(6)));
    assign sampleData = (state == sData) && bitEnd;
    assign stopSample = (state == sStop) && bitEnd;

    // ----------------------------------------
    // frame FSM
    // ----------------------------------------
    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            state      <= sIdle;
            tickCnt    <= '0;
            bitCnt     <= '0;
            parAcc     <= 1'b0;
            parErrPend <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (!rxSync) begin               // falling edge seen
                        tickCnt <= '0;
                        state   <= sStart;
                    end
                end
                sStart: begin
                    if (tick)
                        tickCnt <= tickCnt + 1'b1;
                    if (midStart) begin
                        tickCnt <= '0;               // count from mid start
                        if (rxSync) begin
                            state <= sIdle;          // a glitch and not a start bit
                        end else begin
                            bitCnt     <= '0;
                            parAcc     <= cfg.oddParity;
                            parErrPend <= 1'b0;
                            state      <= sData;
                        end
                    end
                end
                default: begin
                    if (tick)
                        tickCnt <= bitEnd ? '0 : tickCnt + 1'b1;
                    if (bitEnd) begin
                        case (state)
                            sData: begin
                                parAcc <= parAcc ^ rxSync;
                                bitCnt <= bitCnt + 1'b1;
                                if (lastBit)
                                    state <= cfg.parityEn ? sParity : sStop;
                            end
                            sParity: begin
                                parErrPend <= parAcc ^ rxSync;   // nonzero is a mismatch
                                state      <= sStop;
                            end
                            default: state <= sIdle;
                        endcase
                    end
                end
            endcase
        end
    end

    // data bits land by index so bit 7 stays 0 in 7-bit mode
    always_ff @(posedge PCLK) begin
        if (startOk)
            dataReg <= '0;
        else if (sampleData)
            dataReg[bitCnt] <= rxSync;
    end

    always_ff @(posedge PCLK) begin
        if (stopSample)
            rxData <= dataReg;               // overwrites an unread byte
    end

    // ----------------------------------------
    // ready and sticky error flags
    // ----------------------------------------
    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            rxRdy      <= 1'b0;
            overflow   <= 1'b0;
            parityErr  <= 1'b0;
            framingErr <= 1'b0;
        end else if (rxRead) begin
            rxRdy      <= 1'b0;
            overflow   <= 1'b0;
            parityErr  <= 1'b0;
            framingErr <= 1'b0;
        end else if (stopSample) begin
            rxRdy      <= 1'b1;
            overflow   <= overflow | rxRdy;  // previous byte never read
            parityErr  <= parErrPend;
            framingErr <= !rxSync;           // stop bit must be high
        end
    end

    // a read never lands on the cycle a fresh byte is flagged
    rdyRiseNoRead: assert property (
        @(posedge PCLK) disable iff (!PRESETN) $rose(rxRdy) |-> !rxRead
    );

endmodule

// File: hdl/uartTx.sv
`timescale 1ns/1ps

module uartTx (
    input  logic                          PCLK,
    input  logic                          PRESETN,
    input  logic                          tick,
    input  logic                          txWrite,
    input  logic [uartPkg::dataWidth-1:0] txData,
    uartCfgIf.cfgSink                     cfg,
    output logic                          TX,
    output logic                          txRdy
);
    import uartPkg::*;

    localparam logic [2:0] sIdle   = 3'd0;
    localparam logic [2:0] sWait   = 3'd1;   // shifter loaded, waiting for a tick
    localparam logic [2:0] sStart  = 3'd2;
    localparam logic [2:0] sData   = 3'd3;
    localparam logic [2:0] sParity = 3'd4;
    localparam logic [2:0] sStop   = 3'd5;
    localparam int tickBits = $clog2(overSample);
    localparam int bitBits  = $clog2(dataWidth);

    logic [2:0]          state;
    logic [dataWidth-1:0] holdReg;
    logic                holdFull;
    logic [dataWidth-1:0] shiftReg;
    logic [tickBits-1:0] tickCnt;
    logic [bitBits-1:0]  bitCnt;
    logic                parAcc;     // running parity of sent bits
    logic                load;
    logic                bitEnd;
    logic                lastBit;

    assign txRdy   = !holdFull;
    assign load    = (state == sIdle) && holdFull;   // holding reg -> shifter
    assign bitEnd  = tick && (tickCnt == tickBits'(overSample - 1));
    assign lastBit = (bitCnt == (cfg.bit8 ? bitBits'(7) : bitBits'(6)));

    // ----------------------------------------
    // holding register
    // ----------------------------------------
    always_ff @(posedge PCLK) begin
        if (txWrite && !holdFull)
            holdReg <= txData;           // a write while full is dropped
    end

    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN)
            holdFull <= 1'b0;
        else if (txWrite && !holdFull)
            holdFull <= 1'b1;
        else if (load)
            holdFull <= 1'b0;
    end

    always_ff @(posedge PCLK) begin
        if (load)
            shiftReg <= holdReg;
        else if ((state == sData) && bitEnd)
            shiftReg <= shiftReg >> 1;   // LSB first
    end

    // ----------------------------------------
    // frame FSM
    // ----------------------------------------
    always_ff @(posedge PCLK or negedge PRESETN) begin
        if (!PRESETN) begin
            state   <= sIdle;
            TX      <= 1'b1;             // line idles high
            tickCnt <= '0;
            bitCnt  <= '0;
            parAcc  <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (load)
                        state <= sWait;
                end
                sWait: begin
                    if (tick) begin
                        TX      <= 1'b0;          // start bit
                        tickCnt <= '0;
                        bitCnt  <= '0;
                        parAcc  <= cfg.oddParity; // odd parity seeds a one
                        state   <= sStart;
                    end
                end
                default: begin
                    if (tick)
                        tickCnt <= bitEnd ? '0 : tickCnt + 1'b1;
                    if (bitEnd) begin
                        case (state)
                            sStart: begin
                                TX    <= shiftReg[0];
                                state <= sData;
                            end
                            sData: begin
                                parAcc <= parAcc ^ shiftReg[0];
                                bitCnt <= bitCnt + 1'b1;
                                if (!lastBit) begin
                                    TX <= shiftReg[1];
                                end else if (cfg.parityEn) begin
                                    TX    <= parAcc ^ shiftReg[0];
                                    state <= sParity;
                                end else begin
                                    TX    <= 1'b1;
                                    state <= sStop;
                                end
                            end
                            sParity: begin
                                TX    <= 1'b1;    // stop bit
                                state <= sStop;
                            end
                            default: state <= sIdle;  // stop bit done
                        endcase
                    end
                end
            endcase
        end
    end

    idleLineHigh: assert property (
        @(posedge PCLK) disable iff (!PRESETN) (state == sIdle) |-> TX
    );

endmodule

// File: uartApb.f
hdl/uartPkg.sv
hdl/uartCfgIf.sv
hdl/uartApbRegs.sv
hdl/uartBaudGen.sv
hdl/uartTx.sv
hdl/uartRx.sv
hdl/uartApb.sv
dv/uartApbTb.sv
